/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - include
    files:
      - hw/id_pkg.sv
      - hw/decode_if.sv
      - hw/bypass_if.sv
      - hw/regfile.sv
      - hw/inst_decoder.sv
      - hw/operand_bypass.sv
      - hw/branch_resolve.sv
      - hw/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_id_stage.sv

/* hw/branch_resolve.sv */
`timescale 1ns/10ps
`default_nettype none

`include "id_stage_params.svh"

module branch_resolve
    import id_pkg::*;
(
    input  var br_kind_e       br_kind,
    input  wire  [`DATA_W-1:0] rs_value,
    input  wire  [`DATA_W-1:0] rt_value,
    input  wire  [`IMM_W-1:0]  imm,
    input  wire  [`JIDX_W-1:0] jidx,
    input  wire  [`DATA_W-1:0] ds_pc,
    input  wire                ds_valid,
    output logic               br_taken,
    output logic [`DATA_W-1:0] br_target
);
    logic [`DATA_W-1:0] slot_pc;
    logic [`DATA_W-1:0] br_offset;
    logic               rs_neg;
    logic               rs_zero;
    logic               cond;

    // targets count from the delay slot
    assign slot_pc   = ds_pc + `DATA_W'(4);
    assign br_offset = {{(`DATA_W-`IMM_W-`BR_SHIFT){imm[`IMM_W-1]}}, imm, {`BR_SHIFT{1'b0}}};
    assign rs_neg    = rs_value[`DATA_W-1];
    assign rs_zero   = (rs_value == '0);

    always_comb begin
        case (br_kind)
            br_eq:       cond = (rs_value == rt_value);
            br_ne:       cond = (rs_value != rt_value);
            br_gez:      cond = !rs_neg;
            br_gtz:      cond = !rs_neg && !rs_zero;
            br_lez:      cond = rs_neg || rs_zero;
            br_ltz:      cond = rs_neg;
            br_jump_imm,
            br_jump_reg: cond = 1'b1;
            default:     cond = 1'b0;
        endcase
    end

    assign br_taken = ds_valid && cond;

    always_comb begin
        case (br_kind)
            br_jump_reg: br_target = rs_value;
            br_jump_imm: br_target = {slot_pc[`DATA_W-1:`JIDX_W+`BR_SHIFT], jidx, {`BR_SHIFT{1'b0}}};
            default:     br_target = slot_pc + br_offset;
        endcase
    end

endmodule

`default_nettype wire

/* hw/bypass_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "id_stage_params.svh"

interface bypass_if ();
    // execute stage result
    logic               es_rf_we;
    logic [`REG_AW-1:0] es_waddr;
    logic [`DATA_W-1:0] es_wdata;
    logic               es_load_op;
    // memory stage result
    logic               ms_rf_we;
    logic [`REG_AW-1:0] ms_waddr;
    logic [`DATA_W-1:0] ms_wdata;
    // writeback stage result
    logic               ws_rf_we;
    logic [`REG_AW-1:0] ws_waddr;
    logic [`DATA_W-1:0] ws_wdata;

    modport source (
        output es_rf_we, es_waddr, es_wdata, es_load_op,
               ms_rf_we, ms_waddr, ms_wdata,
               ws_rf_we, ws_waddr, ws_wdata
    );

    modport sink (
        input es_rf_we, es_waddr, es_wdata, es_load_op,
              ms_rf_we, ms_waddr, ms_wdata,
              ws_rf_we, ws_waddr, ws_wdata
    );
endinterface

`default_nettype wire

/* hw/decode_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "id_stage_params.svh"

interface decode_if import id_pkg::*; ();
    logic [`REG_AW-1:0] rs_addr;
    logic [`REG_AW-1:0] rt_addr;
    logic [`REG_AW-1:0] dest;
    logic [`DATA_W-1:0] imm;
    logic [`JIDX_W-1:0] jidx;
    alu_op_e            alu_op;
    br_kind_e           br_kind;
    logic               uses_rs;
    logic               uses_rt;
    logic               src1_is_sa;
    logic               src1_is_pc;
    logic               src2_is_imm;
    logic               src2_is_8;
    logic               load_op;
    logic               mem_we;
    logic               rf_we;

    modport decoder (
        output rs_addr, rt_addr, dest, imm, jidx, alu_op, br_kind, uses_rs, uses_rt,
               src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8, load_op, mem_we, rf_we
    );
endinterface

`default_nettype wire

/* hw/id_pkg.sv */
`default_nettype none

package id_pkg;

    // primary opcode field
    typedef enum logic [5:0] {
        op_special = 6'h00, op_regimm = 6'h01,
        op_j       = 6'h02, op_jal    = 6'h03,
        op_beq     = 6'h04, op_bne    = 6'h05,
        op_blez    = 6'h06, op_bgtz   = 6'h07,
        op_addiu   = 6'h09, op_slti   = 6'h0a,
        op_sltiu   = 6'h0b, op_andi   = 6'h0c,
        op_ori     = 6'h0d, op_xori   = 6'h0e,
        op_lui     = 6'h0f, op_lw     = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field under op_special
    typedef enum logic [5:0] {
        fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03,
        fn_jr   = 6'h08, fn_jalr = 6'h09,
        fn_addu = 6'h21, fn_subu = 6'h23,
        fn_and  = 6'h24, fn_or   = 6'h25,
        fn_xor  = 6'h26, fn_nor  = 6'h27,
        fn_slt  = 6'h2a, fn_sltu = 6'h2b
    } funct_e;

    // operation for the execute stage ALU
    typedef enum logic [3:0] {
        alu_add  = 4'd0,  alu_sub = 4'd1,
        alu_slt  = 4'd2,  alu_sltu = 4'd3,
        alu_and  = 4'd4,  alu_nor = 4'd5,
        alu_or   = 4'd6,  alu_xor = 4'd7,
        alu_sll  = 4'd8,  alu_srl = 4'd9,
        alu_sra  = 4'd10, alu_lui = 4'd11
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none     = 4'd0,
        br_eq       = 4'd1, br_ne  = 4'd2,
        br_gez      = 4'd3, br_gtz = 4'd4,
        br_lez      = 4'd5, br_ltz = 4'd6,
        br_jump_imm = 4'd7,
        br_jump_reg = 4'd8
    } br_kind_e;

endpackage

`default_nettype wire

/* hw/id_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "id_stage_params.svh"

module id_stage
    import id_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire                fs_to_ds_valid,
    input  wire  [`DATA_W-1:0] fs_pc,
    input  wire  [`INST_W-1:0] fs_inst,
    output logic               ds_allowin,
    input  wire                es_allowin,
    output logic               ds_to_es_valid,
    output alu_op_e            alu_op,
    output logic               src1_is_sa,
    output logic               src1_is_pc,
    output logic               src2_is_imm,
    output logic               src2_is_8,
    output logic               load_op,
    output logic               mem_we,
    output logic               rf_we,
    output logic [`REG_AW-1:0] dest,
    output logic [`DATA_W-1:0] imm,
    output logic [`DATA_W-1:0] rs_value,
    output logic [`DATA_W-1:0] rt_value,
    output logic [`DATA_W-1:0] ds_pc,
    output logic               br_taken,
    output logic [`DATA_W-1:0] br_target,
    input  wire                es_rf_we,
    input  wire  [`REG_AW-1:0] es_waddr,
    input  wire  [`DATA_W-1:0] es_wdata,
    input  wire                es_load_op,
    input  wire                ms_rf_we,
    input  wire  [`REG_AW-1:0] ms_waddr,
    input  wire  [`DATA_W-1:0] ms_wdata,
    input  wire                ws_rf_we,
    input  wire  [`REG_AW-1:0] ws_waddr,
    input  wire  [`DATA_W-1:0] ws_wdata
);
    logic               ds_valid;
    logic [`INST_W-1:0] ds_inst;
    logic               stall;
    logic [`DATA_W-1:0] rf_rdata1;
    logic [`DATA_W-1:0] rf_rdata2;

    decode_if dec ();
    bypass_if fwd ();

    // hold while stalled or execute is busy
    assign ds_allowin     = !ds_valid || (!stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    assign fwd.es_rf_we   = es_rf_we;
    assign fwd.es_waddr   = es_waddr;
    assign fwd.es_wdata   = es_wdata;
    assign fwd.es_load_op = es_load_op;
    assign fwd.ms_rf_we   = ms_rf_we;
    assign fwd.ms_waddr   = ms_waddr;
    assign fwd.ms_wdata   = ms_wdata;
    assign fwd.ws_rf_we   = ws_rf_we;
    assign fwd.ws_waddr   = ws_waddr;
    assign fwd.ws_wdata   = ws_wdata;

    // decoded controls toward execute
    assign alu_op      = dec.alu_op;
    assign src1_is_sa  = dec.src1_is_sa;
    assign src1_is_pc  = dec.src1_is_pc;
    assign src2_is_imm = dec.src2_is_imm;
    assign src2_is_8   = dec.src2_is_8;
    assign load_op     = dec.load_op;
    assign mem_we      = dec.mem_we;
    assign rf_we       = dec.rf_we;
    assign dest        = dec.dest;
    assign imm         = dec.imm;

    inst_decoder i_decoder (
        .inst (ds_inst),
        .dec  (dec.decoder)
    );

    // writeback port also feeds the bypass
    regfile i_regfile (
        .clk    (clk),
        .raddr1 (dec.rs_addr),
        .rdata1 (rf_rdata1),
        .raddr2 (dec.rt_addr),
        .rdata2 (rf_rdata2),
        .we     (ws_rf_we),
        .waddr  (ws_waddr),
        .wdata  (ws_wdata)
    );

    operand_bypass i_bypass (
        .rs_addr   (dec.rs_addr),
        .rt_addr   (dec.rt_addr),
        .uses_rs   (dec.uses_rs),
        .uses_rt   (dec.uses_rt),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .fwd       (fwd.sink),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .stall     (stall)
    );

    branch_resolve i_branch (
        .br_kind   (dec.br_kind),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .imm       (dec.imm[`IMM_W-1:0]),
        .jidx      (dec.jidx),
        .ds_pc     (ds_pc),
        .ds_valid  (ds_valid),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

`default_nettype wire

/* hw/inst_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "id_stage_params.svh"

module inst_decoder
    import id_pkg::*;
(
    input  wire [`INST_W-1:0] inst,
    decode_if.decoder         dec
);
    opcode_e            op;
    funct_e             fn;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic [`IMM_W-1:0]  imm16;
    logic               zero_ext;
    alu_op_e            alu_r;
    alu_op_e            alu_i;

    assign op    = opcode_e'(inst[`OP_HI:`OP_LO]);
    assign fn    = funct_e'(inst[`FN_HI:`FN_LO]);
    assign rt    = inst[`RT_HI:`RT_LO];
    assign rd    = inst[`RD_HI:`RD_LO];
    assign imm16 = inst[`IMM_W-1:0];

    assign dec.rs_addr = inst[`RS_HI:`RS_LO];
    assign dec.rt_addr = rt;
    assign dec.jidx    = inst[`JIDX_W-1:0];

    // logical immediates zero-extend
    assign zero_ext = (op == op_andi) || (op == op_ori) || (op == op_xori);
    assign dec.imm  = zero_ext ? {{(`DATA_W-`IMM_W){1'b0}}, imm16}
                               : {{(`DATA_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};

    always_comb begin
        case (fn)
            fn_subu: alu_r = alu_sub;
            fn_slt:  alu_r = alu_slt;
            fn_sltu: alu_r = alu_sltu;
            fn_and:  alu_r = alu_and;
            fn_or:   alu_r = alu_or;
            fn_xor:  alu_r = alu_xor;
            fn_nor:  alu_r = alu_nor;
            fn_sll:  alu_r = alu_sll;
            fn_srl:  alu_r = alu_srl;
            fn_sra:  alu_r = alu_sra;
            default: alu_r = alu_add;
        endcase
    end

    always_comb begin
        case (op)
            op_slti:  alu_i = alu_slt;
            op_sltiu: alu_i = alu_sltu;
            op_andi:  alu_i = alu_and;
            op_ori:   alu_i = alu_or;
            op_xori:  alu_i = alu_xor;
            op_lui:   alu_i = alu_lui;
            default:  alu_i = alu_add;
        endcase
    end

    always_comb begin
        dec.alu_op      = alu_add;
        dec.br_kind     = br_none;
        dec.dest        = rd;
        dec.uses_rs     = 1'b0;
        dec.uses_rt     = 1'b0;
        dec.src1_is_sa  = 1'b0;
        dec.src1_is_pc  = 1'b0;
        dec.src2_is_imm = 1'b0;
        dec.src2_is_8   = 1'b0;
        dec.load_op     = 1'b0;
        dec.mem_we      = 1'b0;
        dec.rf_we       = 1'b0;
        case (op)
            op_special: begin
                case (fn)
                    fn_addu, fn_subu, fn_slt, fn_sltu, fn_and, fn_or, fn_xor, fn_nor: begin
                        dec.alu_op  = alu_r;
                        dec.uses_rs = 1'b1;
                        dec.uses_rt = 1'b1;
                        dec.rf_we   = 1'b1;
                    end
                    fn_sll, fn_srl, fn_sra: begin
                        dec.alu_op     = alu_r;
                        dec.uses_rt    = 1'b1;
                        dec.src1_is_sa = 1'b1;
                        dec.rf_we      = 1'b1;
                    end
                    fn_jr: begin
                        dec.uses_rs = 1'b1;
                        dec.br_kind = br_jump_reg;
                    end
                    fn_jalr: begin
                        dec.uses_rs    = 1'b1;
                        dec.br_kind    = br_jump_reg;
                        dec.src1_is_pc = 1'b1;
                        dec.src2_is_8  = 1'b1;
                        dec.rf_we      = 1'b1;
                    end
                    default: ;
                endcase
            end
            // rt selects bltz or bgez
            op_regimm: begin
                if (rt == 5'd0) begin
                    dec.uses_rs = 1'b1;
                    dec.br_kind = br_ltz;
                end else if (rt == 5'd1) begin
                    dec.uses_rs = 1'b1;
                    dec.br_kind = br_gez;
                end
            end
            op_j: dec.br_kind = br_jump_imm;
            op_jal: begin
                dec.br_kind    = br_jump_imm;
                dec.src1_is_pc = 1'b1;
                dec.src2_is_8  = 1'b1;
                dec.rf_we      = 1'b1;
                dec.dest       = `REG_AW'(`LINK_REG);
            end
            op_beq, op_bne: begin
                dec.uses_rs = 1'b1;
                dec.uses_rt = 1'b1;
                dec.br_kind = (op == op_beq) ? br_eq : br_ne;
            end
            op_blez, op_bgtz: begin
                dec.uses_rs = 1'b1;
                dec.br_kind = (op == op_blez) ? br_lez : br_gtz;
            end
            op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui, op_lw: begin
                dec.alu_op      = alu_i;
                dec.uses_rs     = (op != op_lui);
                dec.src2_is_imm = 1'b1;
                dec.load_op     = (op == op_lw);
                dec.rf_we       = 1'b1;
                dec.dest        = rt;
            end
            op_sw: begin
                dec.uses_rs     = 1'b1;
                dec.uses_rt     = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.mem_we      = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/operand_bypass.sv */
`timescale 1ns/10ps
`default_nettype none

`include "id_stage_params.svh"

module operand_bypass (
    input  wire  [`REG_AW-1:0] rs_addr,
    input  wire  [`REG_AW-1:0] rt_addr,
    input  wire                uses_rs,
    input  wire                uses_rt,
    input  wire  [`DATA_W-1:0] rf_rdata1,
    input  wire  [`DATA_W-1:0] rf_rdata2,
    bypass_if.sink             fwd,
    output logic [`DATA_W-1:0] rs_value,
    output logic [`DATA_W-1:0] rt_value,
    output logic               stall
);
    logic rs_es_hit;
    logic rs_ms_hit;
    logic rs_ws_hit;
    logic rt_es_hit;
    logic rt_ms_hit;
    logic rt_ws_hit;

    // r0 never matches
    function automatic logic hit(input logic we, input logic [`REG_AW-1:0] waddr,
                                 input logic [`REG_AW-1:0] raddr);
        return we && (waddr == raddr) && (raddr != '0);
    endfunction

    assign rs_es_hit = hit(fwd.es_rf_we, fwd.es_waddr, rs_addr);
    assign rs_ms_hit = hit(fwd.ms_rf_we, fwd.ms_waddr, rs_addr);
    assign rs_ws_hit = hit(fwd.ws_rf_we, fwd.ws_waddr, rs_addr);
    assign rt_es_hit = hit(fwd.es_rf_we, fwd.es_waddr, rt_addr);
    assign rt_ms_hit = hit(fwd.ms_rf_we, fwd.ms_waddr, rt_addr);
    assign rt_ws_hit = hit(fwd.ws_rf_we, fwd.ws_waddr, rt_addr);

    // youngest result wins
    assign rs_value = rs_es_hit ? fwd.es_wdata :
                      rs_ms_hit ? fwd.ms_wdata :
                      rs_ws_hit ? fwd.ws_wdata : rf_rdata1;
    assign rt_value = rt_es_hit ? fwd.es_wdata :
                      rt_ms_hit ? fwd.ms_wdata :
                      rt_ws_hit ? fwd.ws_wdata : rf_rdata2;

    // load data not ready until memory stage
    assign stall = fwd.es_load_op && ((uses_rs && rs_es_hit) || (uses_rt && rt_es_hit));

endmodule

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "id_stage_params.svh"

module regfile (
    input  wire                clk,
    input  wire  [`REG_AW-1:0] raddr1,
    output logic [`DATA_W-1:0] rdata1,
    input  wire  [`REG_AW-1:0] raddr2,
    output logic [`DATA_W-1:0] rdata2,
    input  wire                we,
    input  wire  [`REG_AW-1:0] waddr,
    input  wire  [`DATA_W-1:0] wdata
);
    logic [`DATA_W-1:0] regs [`REG_CNT];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* id_stage.f */
+incdir+include
hw/id_pkg.sv
hw/decode_if.sv
hw/bypass_if.sv
hw/regfile.sv
hw/inst_decoder.sv
hw/operand_bypass.sv
hw/branch_resolve.sv
hw/id_stage.sv
verification/tb_id_stage.sv

/* include/id_stage_params.svh */
`ifndef ID_STAGE_PARAMS_SVH
`define ID_STAGE_PARAMS_SVH

// datapath and register file
`define DATA_W   32
`define REG_CNT  32
`define REG_AW   5
`define INST_W   32
`define IMM_W    16
`define JIDX_W   26

// link register written by jal
`define LINK_REG 31

// instruction word fields
`define OP_HI    31
`define OP_LO    26
`define RS_HI    25
`define RS_LO    21
`define RT_HI    20
`define RT_LO    16
`define RD_HI    15
`define RD_LO    11
`define FN_HI    5
`define FN_LO    0

// word offset to byte offset
`define BR_SHIFT 2

`endif

/* verification/id_stage_vectors.txt */
// test fs_valid fs_pc fs_inst es_allowin  es: we addr data load  ms: we addr data  ws: we addr data
// mask(0 rs 1 rt 2 dest 3 alu 4 imm 5 tgt) ds_allowin ds_to_es_valid rs rt dest alu imm taken tgt
1 1 100 24228000 1  0 0 0 0  0 0 0  1 1 1234  0 1 0 0 0 0 0 0 0 0
1 1 104 34238000 1  0 0 0 0  0 0 0  1 2 5678  1d 1 1 1234 0 2 0 ffff8000 0 0
1 1 108 3c04abcd 1  0 0 0 0  0 0 0  0 0 0  1d 1 1 1234 0 3 6 8000 0 0
1 1 10c 00222821 1  0 0 0 0  0 0 0  0 0 0  1d 1 1 0 0 4 b ffffabcd 0 0
1 1 110 00223023 1  0 0 0 0  0 0 0  0 0 0  f 1 1 1234 5678 5 0 0 0 0
2 1 110 00223023 1  1 1 aaaa 0  1 1 bbbb  1 1 cccc  f 1 1 aaaa 5678 6 1 0 0 0
2 1 110 00223023 1  0 0 0 0  1 1 bbbb  1 1 cccc  f 1 1 bbbb 5678 6 1 0 0 0
2 1 114 00023821 1  0 0 0 0  0 0 0  1 1 dddd  f 1 1 dddd 5678 6 1 0 0 0
2 1 118 00224021 1  1 0 eeee 0  1 0 eeee  1 0 ffff  f 1 1 0 5678 7 0 0 0 0
3 1 11c 00224827 1  1 1 0 1  0 0 0  0 0 0  e 0 0 0 5678 8 0 0 0 0
3 1 11c 00224827 1  1 1 0 1  0 0 0  0 0 0  e 0 0 0 5678 8 0 0 0 0
3 1 11c 00225026 1  0 0 0 0  1 1 1357  0 0 0  f 1 1 1357 5678 8 0 0 0 0
4 1 120 0022582b 0  0 0 0 0  0 0 0  0 0 0  f 0 1 dddd 5678 a 7 0 0 0
4 1 120 0022582b 0  0 0 0 0  0 0 0  0 0 0  f 0 1 dddd 5678 a 7 0 0 0
4 1 120 0022582b 1  0 0 0 0  0 0 0  1 3 fffffff0  f 1 1 dddd 5678 a 7 0 0 0
4 1 200 10220004 1  0 0 0 0  0 0 0  0 0 0  f 1 1 dddd 5678 b 3 0 0 0
5 1 204 1422fffc 1  0 0 0 0  0 0 0  0 0 0  23 1 1 dddd 5678 0 0 0 0 214
5 1 208 04010008 1  0 0 0 0  0 0 0  0 0 0  23 1 1 dddd 5678 0 0 0 1 1f8
5 1 20c 1c000008 1  0 0 0 0  0 0 0  0 0 0  21 1 1 0 0 0 0 0 1 22c
5 1 210 18600008 1  0 0 0 0  0 0 0  0 0 0  21 1 1 0 0 0 0 0 0 230
5 1 214 04200008 1  0 0 0 0  0 0 0  0 0 0  21 1 1 fffffff0 0 0 0 0 1 234
5 1 218 04610008 1  0 0 0 0  0 0 0  0 0 0  21 1 1 dddd 0 0 0 0 0 238
5 1 21c 08000100 1  0 0 0 0  0 0 0  0 0 0  21 1 1 fffffff0 0 0 0 0 0 23c
5 1 f0000400 0c000200 1  0 0 0 0  0 0 0  0 0 0  20 1 1 0 0 0 0 0 1 400
5 1 f0000404 00a00008 1  0 0 0 0  0 0 0  0 0 0  24 1 1 0 0 1f 0 0 1 f0000800
5 0 0 0 1  1 5 1230 0  0 0 0  0 0 0  21 1 1 1230 0 0 0 0 1 1230
5 0 0 0 1  0 0 0 0  0 0 0  0 0 0  0 1 0 0 0 0 0 0 0 0
0

/* verification/tb_id_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "id_stage_params.svh"

module tb_id_stage
    import id_pkg::*;
();
    localparam int FIELDS  = 25;
    localparam int MAX_VEC = 64;

    logic               clk;
    logic               reset;
    logic               fs_to_ds_valid;
    logic [`DATA_W-1:0] fs_pc;
    logic [`INST_W-1:0] fs_inst;
    logic               ds_allowin;
    logic               es_allowin;
    logic               ds_to_es_valid;
    alu_op_e            alu_op;
    logic               src1_is_sa;
    logic               src1_is_pc;
    logic               src2_is_imm;
    logic               src2_is_8;
    logic               load_op;
    logic               mem_we;
    logic               rf_we;
    logic [`REG_AW-1:0] dest;
    logic [`DATA_W-1:0] imm;
    logic [`DATA_W-1:0] rs_value;
    logic [`DATA_W-1:0] rt_value;
    logic [`DATA_W-1:0] ds_pc;
    logic               br_taken;
    logic [`DATA_W-1:0] br_target;
    logic               es_rf_we;
    logic [`REG_AW-1:0] es_waddr;
    logic [`DATA_W-1:0] es_wdata;
    logic               es_load_op;
    logic               ms_rf_we;
    logic [`REG_AW-1:0] ms_waddr;
    logic [`DATA_W-1:0] ms_wdata;
    logic               ws_rf_we;
    logic [`REG_AW-1:0] ws_waddr;
    logic [`DATA_W-1:0] ws_wdata;

    // one vector is FIELDS words in a row
    logic [31:0] vec_mem [FIELDS*MAX_VEC];
    int          vec_count;
    int          cycle;
    int          cycle_limit;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    // instruction the stage should be holding
    logic               held_valid;
    logic [`DATA_W-1:0] held_pc;
    logic [`INST_W-1:0] held_inst;

    id_stage i_id_stage (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
        if (cycle > cycle_limit) begin
            $display("Timeout: the vectors did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error: %s expected %h, got %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic apply_inputs(input int base);
        fs_to_ds_valid = vec_mem[base+1][0];
        fs_pc          = vec_mem[base+2];
        fs_inst        = vec_mem[base+3];
        es_allowin     = vec_mem[base+4][0];
        es_rf_we       = vec_mem[base+5][0];
        es_waddr       = vec_mem[base+6][`REG_AW-1:0];
        es_wdata       = vec_mem[base+7];
        es_load_op     = vec_mem[base+8][0];
        ms_rf_we       = vec_mem[base+9][0];
        ms_waddr       = vec_mem[base+10][`REG_AW-1:0];
        ms_wdata       = vec_mem[base+11];
        ws_rf_we       = vec_mem[base+12][0];
        ws_waddr       = vec_mem[base+13][`REG_AW-1:0];
        ws_wdata       = vec_mem[base+14];
    endtask

    // {rf_we, mem_we, load_op, src2_is_8, src2_is_imm, src1_is_pc, src1_is_sa} per instruction
    function automatic logic [6:0] expected_ctrl(input logic [31:0] inst);
        logic [6:0] ctrl;
        ctrl = 7'b0;
        case (inst[31:26])
            6'h00: begin
                case (inst[5:0])
                    6'h00, 6'h02, 6'h03: ctrl = 7'b1000001;
                    6'h09: ctrl = 7'b1001010;
                    6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b: ctrl = 7'b1000000;
                    default: ;
                endcase
            end
            6'h03: ctrl = 7'b1001010;
            6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: ctrl = 7'b1000100;
            6'h23: ctrl = 7'b1010100;
            6'h2b: ctrl = 7'b0100100;
            default: ;
        endcase
        return ctrl;
    endfunction

    // flow and br_taken always, the rest by mask bit
    task automatic check_outputs(input int base);
        logic [31:0] mask;
        logic [6:0]  ctrl;
        mask = vec_mem[base+15];
        check_value("ds_allowin", vec_mem[base+16], ds_allowin);
        check_value("ds_to_es_valid", vec_mem[base+17], ds_to_es_valid);
        check_value("br_taken", vec_mem[base+23], br_taken);
        if (mask[0]) check_value("rs_value", vec_mem[base+18], rs_value);
        if (mask[1]) check_value("rt_value", vec_mem[base+19], rt_value);
        if (mask[2]) check_value("dest", vec_mem[base+20], dest);
        if (mask[3]) check_value("alu_op", vec_mem[base+21], alu_op);
        if (mask[4]) check_value("imm", vec_mem[base+22], imm);
        if (mask[5]) check_value("br_target", vec_mem[base+24], br_target);
        if (held_valid) begin
            ctrl = expected_ctrl(held_inst);
            check_value("ds_pc", held_pc, ds_pc);
            check_value("rf_we", ctrl[6], rf_we);
            check_value("mem_we", ctrl[5], mem_we);
            check_value("load_op", ctrl[4], load_op);
            check_value("src2_is_8", ctrl[3], src2_is_8);
            check_value("src2_is_imm", ctrl[2], src2_is_imm);
            check_value("src1_is_pc", ctrl[1], src1_is_pc);
            check_value("src1_is_sa", ctrl[0], src1_is_sa);
        end
    endtask

    // capture follows the expected ds_allowin of the vector
    task automatic track_stage(input int base);
        if (vec_mem[base+16][0]) begin
            held_valid = vec_mem[base+1][0];
            if (vec_mem[base+1][0]) begin
                held_pc   = vec_mem[base+2];
                held_inst = vec_mem[base+3];
            end
        end
    endtask

    task automatic finish_test(input int id);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d finished: ok", id);
        end else begin
            tests_failed++;
            $display("test %0d finished: %0d errors", id, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_pc          = '0;
        fs_inst        = '0;
        es_allowin     = 1'b0;
        es_rf_we       = 1'b0;
        es_waddr       = '0;
        es_wdata       = '0;
        es_load_op     = 1'b0;
        ms_rf_we       = 1'b0;
        ms_waddr       = '0;
        ms_wdata       = '0;
        ws_rf_we       = 1'b0;
        ws_waddr       = '0;
        ws_wdata       = '0;
        cycle          = 0;
        cycle_limit    = MAX_VEC + 20;
        test_errors    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        held_valid     = 1'b0;
        held_pc        = '0;
        held_inst      = '0;

        $readmemh("verification/id_stage_vectors.txt", vec_mem);
        // a test id of zero ends the list
        vec_count = 0;
        while (vec_count < MAX_VEC && vec_mem[vec_count*FIELDS] != 0) begin
            vec_count++;
        end
        assert (vec_count > 0) else begin
            $display("No test vectors were read from the vector file");
            tests_failed++;
        end
        cycle_limit = vec_count + 20;

        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        for (int v = 0; v < vec_count; v++) begin
            apply_inputs(v*FIELDS);
            #18;
            check_outputs(v*FIELDS);
            track_stage(v*FIELDS);
            if (v == vec_count-1 || vec_mem[(v+1)*FIELDS] != vec_mem[v*FIELDS]) begin
                finish_test(vec_mem[v*FIELDS]);
            end
            @(posedge clk);
            #1;
        end

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
